// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = fft8_tb
FILELIST = project.f

BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = STATUS: PASS

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
source/fft_pkg.sv
source/fft_pass_if.sv
source/fft_sequencer.sv
source/operand_select.sv
source/cplx_twiddle_mul.sv
source/butterfly_stage.sv
source/fft8_top.sv
testbench/tb_clock_gen.sv
testbench/fft8_tb.sv

// ==== source/butterfly_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module butterfly_stage (
	input  logic i_clk,
	input  logic i_rst,
	fft_pass_if.bfly pass_bus
);

	fft_pkg::idx_t top_idx [fft_pkg::N_BFLY];
	fft_pkg::idx_t bot_idx [fft_pkg::N_BFLY];
	fft_pkg::cplx_t top_out [fft_pkg::N_BFLY];
	fft_pkg::cplx_t bot_out [fft_pkg::N_BFLY];
	fft_pkg::cplx_vec_t next_vec;
	fft_pkg::cplx_vec_t result_q;

	// pairs are span = 2^p apart, grouped in blocks of 2*span
	function automatic fft_pkg::idx_t top_index(input int b, input fft_pkg::pass_t p);
		int span;
		span = 1 << p;
		return fft_pkg::idx_t'(((b >> p) << (p + 1)) | (b & (span - 1)));
	endfunction

	function automatic fft_pkg::idx_t bot_index(input int b, input fft_pkg::pass_t p);
		int span;
		span = 1 << p;
		return fft_pkg::idx_t'(int'(top_index(b, p)) + span);
	endfunction

	// position inside the block times N/(2*span) picks the twiddle
	function automatic fft_pkg::tw_idx_t twiddle_index(input int b, input fft_pkg::pass_t p);
		int span;
		span = 1 << p;
		return fft_pkg::tw_idx_t'((b & (span - 1)) << (fft_pkg::N_PASSES - 1 - p));
	endfunction

	for (genvar b = 0; b < fft_pkg::N_BFLY; b++) begin : g_bfly
		fft_pkg::cplx_t top_op;
		fft_pkg::cplx_t bot_op;
		fft_pkg::cplx_t twiddle;
		fft_pkg::cplx_t bot_rot;

		assign top_idx[b] = top_index(b, pass_bus.pass);
		assign bot_idx[b] = bot_index(b, pass_bus.pass);

		assign top_op = pass_bus.operands[top_idx[b]];
		assign bot_op = pass_bus.operands[bot_idx[b]];
		assign twiddle = fft_pkg::TWIDDLE[twiddle_index(b, pass_bus.pass)];

		cplx_twiddle_mul u_mul (
			.i_a(bot_op),
			.i_w(twiddle),
			.o_p(bot_rot)
		);

		// nothing is scaled here so the sums simply wrap at the word width
		assign top_out[b] = '{
			re: top_op.re + bot_rot.re,
			im: top_op.im + bot_rot.im
		};
		assign bot_out[b] = '{
			re: top_op.re - bot_rot.re,
			im: top_op.im - bot_rot.im
		};
	end

	// every index is hit exactly once per pass, so results go back in place
	always_comb begin
		next_vec = '0;
		for (int b = 0; b < fft_pkg::N_BFLY; b++) begin
			next_vec[top_idx[b]] = top_out[b];
			next_vec[bot_idx[b]] = bot_out[b];
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			result_q <= '0;
		end else if (pass_bus.wr_en) begin
			result_q <= next_vec;
		end
	end

	assign pass_bus.results = result_q;

endmodule

`default_nettype wire

// ==== source/cplx_twiddle_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

module cplx_twiddle_mul (
	input  fft_pkg::cplx_t i_a,
	input  fft_pkg::cplx_t i_w,
	output fft_pkg::cplx_t o_p
);

	logic signed [2*fft_pkg::WORD_W-1:0] pp_rr;
	logic signed [2*fft_pkg::WORD_W-1:0] pp_ii;
	logic signed [2*fft_pkg::WORD_W-1:0] pp_ri;
	logic signed [2*fft_pkg::WORD_W-1:0] pp_ir;
	logic signed [2*fft_pkg::WORD_W:0] sum_re;
	logic signed [2*fft_pkg::WORD_W:0] sum_im;
	logic signed [2*fft_pkg::WORD_W:0] scaled_re;
	logic signed [2*fft_pkg::WORD_W:0] scaled_im;

	assign pp_rr = $signed(i_a.re) * $signed(i_w.re);
	assign pp_ii = $signed(i_a.im) * $signed(i_w.im);
	assign pp_ri = $signed(i_a.re) * $signed(i_w.im);
	assign pp_ir = $signed(i_a.im) * $signed(i_w.re);

	// keep one extra bit so the sums themselves cannot overflow
	assign sum_re = pp_rr - pp_ii;
	assign sum_im = pp_ri + pp_ir;

	// the arithmetic shift rounds toward minus infinity
	assign scaled_re = sum_re >>> fft_pkg::FRAC_W;
	assign scaled_im = sum_im >>> fft_pkg::FRAC_W;

	assign o_p = '{
		re: scaled_re[fft_pkg::WORD_W-1:0],
		im: scaled_im[fft_pkg::WORD_W-1:0]
	};

endmodule

`default_nettype wire

// ==== source/fft8_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft8_top (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  fft_pkg::cplx_vec_t i_x,
	output fft_pkg::cplx_vec_t o_x,
	output logic o_done,
	output logic o_busy
);

	fft_pass_if pass_bus ();

	// steps the three passes and flags the end of a transform
	fft_sequencer u_fft_sequencer (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(i_start),
		.o_done(o_done),
		.o_busy(o_busy),
		.pass_bus(pass_bus.seq)
	);

	// fresh samples on pass 0, stored results afterwards
	operand_select u_operand_select (
		.i_x(i_x),
		.pass_bus(pass_bus.sel)
	);

	butterfly_stage u_butterfly_stage (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.pass_bus(pass_bus.bfly)
	);

	// the result bank holds the finished transform until the next start
	assign o_x = pass_bus.results;

endmodule

`default_nettype wire

// ==== source/fft_pass_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface fft_pass_if;

	fft_pkg::pass_t pass;
	logic wr_en;
	fft_pkg::cplx_vec_t operands;
	fft_pkg::cplx_vec_t results;

	modport seq (
		output pass,
		output wr_en
	);

	// operand selection needs the stored results for the later passes
	modport sel (
		input  pass,
		input  results,
		output operands
	);

	modport bfly (
		input  pass,
		input  wr_en,
		input  operands,
		output results
	);

endinterface

`default_nettype wire

// ==== source/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

	// sample format is two signed parts per point
	localparam int WORD_W = 16;

	// twiddle factors are Q.8 so a product is shifted back by this amount
	localparam int FRAC_W = 8;

	localparam int N_POINTS = 8;
	localparam int N_BFLY = N_POINTS / 2;
	localparam int N_PASSES = $clog2(N_POINTS);

	localparam int IDX_W = $clog2(N_POINTS);
	localparam int TW_W = $clog2(N_BFLY);
	localparam int PASS_W = $clog2(N_PASSES);

	typedef logic [PASS_W-1:0] pass_t;
	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TW_W-1:0] tw_idx_t;

	localparam pass_t LAST_PASS = pass_t'(N_PASSES - 1);

	typedef struct packed {
		logic signed [WORD_W-1:0] re;
		logic signed [WORD_W-1:0] im;
	} cplx_t;

	// element 0 sits in the low bits of the packed vector
	typedef cplx_t [N_POINTS-1:0] cplx_vec_t;

	// W8^k = exp(-j*2*pi*k/8) scaled by 2^FRAC_W, for k = 0 to 3
	localparam cplx_t TWIDDLE [N_BFLY] = '{
		'{re: WORD_W'(256), im: WORD_W'(0)},
		'{re: WORD_W'(181), im: WORD_W'(-181)},
		'{re: WORD_W'(0), im: WORD_W'(-256)},
		'{re: WORD_W'(-181), im: WORD_W'(-181)}
	};

endpackage

`default_nettype wire

// ==== source/fft_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft_sequencer (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	output logic o_done,
	output logic o_busy,
	fft_pass_if.seq pass_bus
);

	logic busy_q;
	logic done_q;
	fft_pkg::pass_t pass_q;
	logic accept;
	logic last_write;

	// a start strobe only counts while no transform is in flight
	assign accept = i_start & ~busy_q;

	assign last_write = busy_q && (pass_q == fft_pkg::LAST_PASS);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_q <= 1'b0;
			pass_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= last_write;
			if (accept) begin
				// pass 0 is written on this edge, so the next write is pass 1
				busy_q <= 1'b1;
				pass_q <= fft_pkg::pass_t'(1);
			end else if (last_write) begin
				busy_q <= 1'b0;
				pass_q <= '0;
			end else if (busy_q) begin
				pass_q <= pass_q + 1'b1;
			end
		end
	end

	// the first write happens in the accepting cycle itself
	assign pass_bus.wr_en = accept | busy_q;
	assign pass_bus.pass = pass_q;

	assign o_busy = busy_q;
	assign o_done = done_q;

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_select (
	input  fft_pkg::cplx_vec_t i_x,
	fft_pass_if.sel pass_bus
);

	fft_pkg::cplx_vec_t reversed;

	function automatic fft_pkg::idx_t bit_rev(input fft_pkg::idx_t idx);
		fft_pkg::idx_t rev;
		for (int k = 0; k < fft_pkg::IDX_W; k++) begin
			rev[k] = idx[fft_pkg::IDX_W-1-k];
		end
		return rev;
	endfunction

	// decimation in time wants the inputs in bit-reversed order on the first pass
	always_comb begin
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			reversed[i] = i_x[bit_rev(fft_pkg::idx_t'(i))];
		end
	end

	// later passes work in place on what the butterfly bank stored last
	always_comb begin
		if (pass_bus.pass == '0) begin
			pass_bus.operands = reversed;
		end else begin
			pass_bus.operands = pass_bus.results;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/fft8_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft8_tb;

	// the tests need about 100 cycles, so this only trips on a hung run
	localparam int MAX_CYCLES = 2000;
	localparam int DONE_WAIT = 10;
	localparam int N_RANDOM = 20;

	logic i_clk;
	logic i_rst;
	logic i_start;
	fft_pkg::cplx_vec_t i_x;
	fft_pkg::cplx_vec_t o_x;
	logic o_done;
	logic o_busy;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	tb_clock_gen #(.PERIOD_NS(100)) u_tb_clock_gen (
		.o_clk(i_clk)
	);

	fft8_top u_fft8_top (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(i_start),
		.i_x(i_x),
		.o_x(o_x),
		.o_done(o_done),
		.o_busy(o_busy)
	);

	// W8^k scaled by 256
	function automatic int twiddle_re(input int k);
		case (k)
			0: return 256;
			1: return 181;
			2: return 0;
			default: return -181;
		endcase
	endfunction

	function automatic int twiddle_im(input int k);
		case (k)
			0: return 0;
			1: return -181;
			2: return -256;
			default: return -181;
		endcase
	endfunction

	// reference transform that follows the fixed-point rules bit for bit
	function automatic fft_pkg::cplx_vec_t model_fft(input fft_pkg::cplx_vec_t x);
		fft_pkg::cplx_vec_t cur;
		fft_pkg::cplx_vec_t nxt;
		int h;
		int top;
		int bot;
		int tw;
		int rev;
		longint prod_re;
		longint prod_im;
		longint shifted_re;
		longint shifted_im;
		logic signed [fft_pkg::WORD_W-1:0] top_re;
		logic signed [fft_pkg::WORD_W-1:0] top_im;
		logic signed [fft_pkg::WORD_W-1:0] bot_re;
		logic signed [fft_pkg::WORD_W-1:0] bot_im;
		logic signed [fft_pkg::WORD_W-1:0] rot_re;
		logic signed [fft_pkg::WORD_W-1:0] rot_im;
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			rev = ((i & 1) << 2) | (i & 2) | ((i >> 2) & 1);
			cur[i] = x[rev];
		end
		for (int p = 0; p < fft_pkg::N_PASSES; p++) begin
			h = 1 << p;
			nxt = cur;
			for (int b = 0; b < fft_pkg::N_BFLY; b++) begin
				top = (b / h) * 2 * h + (b % h);
				bot = top + h;
				tw = (b % h) * (4 / h);
				top_re = cur[top].re;
				top_im = cur[top].im;
				bot_re = cur[bot].re;
				bot_im = cur[bot].im;
				prod_re = longint'(bot_re) * twiddle_re(tw) - longint'(bot_im) * twiddle_im(tw);
				prod_im = longint'(bot_re) * twiddle_im(tw) + longint'(bot_im) * twiddle_re(tw);
				shifted_re = prod_re >>> fft_pkg::FRAC_W;
				shifted_im = prod_im >>> fft_pkg::FRAC_W;
				rot_re = shifted_re[fft_pkg::WORD_W-1:0];
				rot_im = shifted_im[fft_pkg::WORD_W-1:0];
				nxt[top].re = top_re + rot_re;
				nxt[top].im = top_im + rot_im;
				nxt[bot].re = top_re - rot_re;
				nxt[bot].im = top_im - rot_im;
			end
			cur = nxt;
		end
		return cur;
	endfunction

	function automatic logic signed [fft_pkg::WORD_W-1:0] random_part();
		int r;
		r = int'($urandom_range(511, 0)) - 256;
		return r[fft_pkg::WORD_W-1:0];
	endfunction

	function automatic fft_pkg::cplx_vec_t random_vec();
		fft_pkg::cplx_vec_t v;
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			v[i].re = random_part();
			v[i].im = random_part();
		end
		return v;
	endfunction

	task automatic check_vec(input fft_pkg::cplx_vec_t got, input fft_pkg::cplx_vec_t exp,
		input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s does not match", $time, what);
			for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
				if (got[i] !== exp[i]) begin
					$display("        point %0d is (%0d, %0d), expected (%0d, %0d)", i,
						$signed(got[i].re), $signed(got[i].im),
						$signed(exp[i].re), $signed(exp[i].im));
				end
			end
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// inputs change and outputs are read 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	task automatic start_transform(input fft_pkg::cplx_vec_t vec);
		i_x = vec;
		i_start = 1'b1;
		next_cycle();
		i_start = 1'b0;
	endtask

	task automatic wait_for_done();
		int waited;
		waited = 0;
		while (!o_done && waited < DONE_WAIT) begin
			next_cycle();
			waited++;
		end
		if (!o_done) begin
			error_count++;
			$display("o_done did not rise within %0d cycles of a start", DONE_WAIT);
		end
	endtask

	task automatic run_and_check(input fft_pkg::cplx_vec_t vec, input string what);
		start_transform(vec);
		wait_for_done();
		check_vec(o_x, model_fft(vec), what);
	endtask

	task automatic test_reset_state();
		check_bit(o_done, 1'b0, "o_done after reset");
		check_bit(o_busy, 1'b0, "o_busy after reset");
		check_vec(o_x, '0, "o_x after reset");
	endtask

	task automatic test_impulse();
		fft_pkg::cplx_vec_t vec;
		fft_pkg::cplx_vec_t exp;
		vec = '0;
		vec[0] = '{re: 16'sd100, im: -16'sd50};
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			exp[i] = '{re: 16'sd100, im: -16'sd50};
		end
		start_transform(vec);
		wait_for_done();
		check_vec(o_x, exp, "impulse transform");
	endtask

	task automatic test_constant();
		fft_pkg::cplx_vec_t vec;
		fft_pkg::cplx_vec_t exp;
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			vec[i] = '{re: 16'sd20, im: 16'sd7};
		end
		exp = '0;
		exp[0] = '{re: 16'sd160, im: 16'sd56};
		start_transform(vec);
		wait_for_done();
		check_vec(o_x, exp, "constant input transform");
	endtask

	task automatic test_random();
		for (int n = 0; n < N_RANDOM; n++) begin
			run_and_check(random_vec(), $sformatf("random transform %0d", n));
		end
	endtask

	task automatic test_latency_restart();
		fft_pkg::cplx_vec_t first_vec;
		fft_pkg::cplx_vec_t second_vec;
		first_vec = random_vec();
		second_vec = random_vec();
		i_x = first_vec;
		i_start = 1'b1;
		next_cycle();
		check_bit(o_busy, 1'b1, "o_busy after edge n");
		check_bit(o_done, 1'b0, "o_done after edge n");
		// start stays high with other data while the passes run
		i_x = second_vec;
		next_cycle();
		check_bit(o_busy, 1'b1, "o_busy after edge n+1");
		check_bit(o_done, 1'b0, "o_done after edge n+1");
		next_cycle();
		i_start = 1'b0;
		check_bit(o_done, 1'b1, "o_done after edge n+2");
		check_bit(o_busy, 1'b0, "o_busy after edge n+2");
		check_vec(o_x, model_fft(first_vec), "result with ignored restart");
		next_cycle();
		check_bit(o_done, 1'b0, "o_done after edge n+3");
	endtask

	task automatic test_hold_back_to_back();
		fft_pkg::cplx_vec_t first_vec;
		fft_pkg::cplx_vec_t second_vec;
		first_vec = random_vec();
		second_vec = random_vec();
		start_transform(first_vec);
		wait_for_done();
		check_vec(o_x, model_fft(first_vec), "first of back-to-back pair");
		// the cycle with o_done is the first one where a start counts again
		start_transform(second_vec);
		check_bit(o_busy, 1'b1, "o_busy after back-to-back start");
		wait_for_done();
		check_vec(o_x, model_fft(second_vec), "second of back-to-back pair");
		i_x = random_vec();
		for (int c = 0; c < 10; c++) begin
			next_cycle();
			check_vec(o_x, model_fft(second_vec),
				$sformatf("held result after %0d idle cycles", c + 1));
			check_bit(o_busy, 1'b0, "o_busy while idle");
		end
	endtask

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int unsigned seed_value;
		seed_value = $urandom(67941);
		i_rst = 1'b1;
		i_start = 1'b0;
		i_x = '0;
		repeat (5) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		next_cycle();

		test_reset_state();
		test_impulse();
		test_constant();
		test_random();
		test_latency_restart();
		test_hold_back_to_back();

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire
